// ==== all.f ====
+incdir+design
design/bus_pkg.sv
design/block_pkg.sv
design/byte_fifo.sv
design/extract_fifo.sv
design/wb_block_regs.sv
design/block_collector_top.sv
verif/tb_block_collector.sv

// ==== design/blk_params.svh ====
// Block collector parameters
`ifndef BLK_PARAMS_SVH
`define BLK_PARAMS_SVH

// Bytes per block, also the byte FIFO depth
`define BLK_BYTES 16

// Assembled block width in bits
`define BLK_WIDTH 128

// Wishbone data width and byte address width
`define WB_DW 32
`define WB_AW 5

`endif

// ==== design/block_collector_top.sv ====
// Block collector top level
`timescale 1ns/1ps
`include "blk_params.svh"

module block_collector_top import block_pkg::*; (
	input  logic                 clk,
	input  logic                 n_rst,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  logic [`WB_AW-1:0]    adr,
	input  logic [`WB_DW-1:0]    dat_i,
	input  logic [`WB_DW/8-1:0]  sel,
	output logic [`WB_DW-1:0]    dat_o,
	output logic                 ack
);

	logic push;
	logic [7:0] wdata;
	logic pop;
	logic [7:0] rdata;
	logic fifo_full;
	logic ready;
	block_t block;
	logic blk_release;

	wb_block_regs regs0 (
		.clk(clk),
		.n_rst(n_rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_i(dat_i),
		.sel(sel),
		.dat_o(dat_o),
		.ack(ack),
		.fifo_full(fifo_full),
		.push(push),
		.wdata(wdata),
		.ready(ready),
		.block(block),
		.blk_release(blk_release)
	);

	// Empty flag only matters inside the FIFO
	byte_fifo fifo0 (
		.clk(clk),
		.n_rst(n_rst),
		.push(push),
		.wdata(wdata),
		.pop(pop),
		.rdata(rdata),
		.full(fifo_full),
		.empty()
	);

	extract_fifo extract0 (
		.clk(clk),
		.n_rst(n_rst),
		.full(fifo_full),
		.data(rdata),
		.blk_release(blk_release),
		.pop(pop),
		.ready(ready),
		.block(block)
	);

endmodule

// ==== design/block_pkg.sv ====
// Block data view
package block_pkg;

	`include "blk_params.svh"

	localparam int BLK_WORDS = `BLK_WIDTH / `WB_DW;

	// One block seen either as bytes or as bus words
	// Byte 0 and word 0 sit at the low end
	typedef union packed {
		logic [`BLK_BYTES-1:0][7:0]       bytes;
		logic [BLK_WORDS-1:0][`WB_DW-1:0] words;
	} block_t;

endpackage

// ==== design/bus_pkg.sv ====
// Wishbone register map
package bus_pkg;

	`include "blk_params.svh"

	// Word aligned byte addresses of the slave registers
	typedef enum logic [`WB_AW-1:0] {
		DATA   = 5'h00,
		STATUS = 5'h04,
		BLK0   = 5'h10,
		BLK1   = 5'h14,
		BLK2   = 5'h18,
		BLK3   = 5'h1C
	} reg_addr_t;

	// Status register bits
	localparam int STAT_VALID = 0;
	localparam int STAT_FULL  = 1;

endpackage

// ==== design/byte_fifo.sv ====
// Byte FIFO
`timescale 1ns/1ps
`include "blk_params.svh"

module byte_fifo (
	input  logic       clk,
	input  logic       n_rst,
	input  logic       push,
	input  logic [7:0] wdata,
	input  logic       pop,
	output logic [7:0] rdata,
	output logic       full,
	output logic       empty
);

	localparam int AW = $clog2(`BLK_BYTES);
	localparam logic [AW-1:0] LAST_SLOT = AW'(`BLK_BYTES - 1);
	localparam logic [AW:0] DEPTH = (AW + 1)'(`BLK_BYTES);

	logic [7:0] mem [`BLK_BYTES];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic do_push;
	logic do_pop;

	// Ignore requests that would overrun or underrun
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = (count == DEPTH);
	assign empty = (count == '0);

	// First word fall through
	assign rdata = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Bus side must hold back while full
	assert property (@(posedge clk) disable iff (!n_rst) push |-> !full)
		else $error("byte_fifo: push while full");

	// Extractor must only drain a filled FIFO
	assert property (@(posedge clk) disable iff (!n_rst) pop |-> !empty)
		else $error("byte_fifo: pop while empty");

endmodule

// ==== design/extract_fifo.sv ====
// Block extractor
`timescale 1ns/1ps
`include "blk_params.svh"

module extract_fifo import block_pkg::*; (
	input  logic       clk,
	input  logic       n_rst,
	input  logic       full,
	input  logic [7:0] data,
	input  logic       blk_release,
	output logic       pop,
	output logic       ready,
	output block_t     block
);

	localparam int CW = $clog2(`BLK_BYTES);
	localparam logic [CW-1:0] LAST_BYTE = CW'(`BLK_BYTES - 1);

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		HOLD
	} state_t;

	state_t state;
	state_t next_state;
	logic [CW-1:0] byte_cnt;
	block_t blk_q;

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (full)
					next_state = LOAD;
			end
			LOAD: begin
				if (byte_cnt == LAST_BYTE)
					next_state = HOLD;
			end
			HOLD: begin
				if (blk_release)
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= IDLE;
			byte_cnt <= '0;
		end else begin
			state <= next_state;
			// Counter only runs while loading
			if (state == LOAD && byte_cnt != LAST_BYTE)
				byte_cnt <= byte_cnt + 1'b1;
			else
				byte_cnt <= '0;
		end
	end

	// One popped byte per cycle into the next lane
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			blk_q <= '0;
		else if (pop)
			blk_q.bytes[byte_cnt] <= data;
	end

	assign pop = (state == LOAD);
	assign ready = (state == HOLD);
	assign block = blk_q;

	// A load is one unbroken run of pops before the block is held
	assert property (@(posedge clk) disable iff (!n_rst)
		$rose(pop) |-> pop [*`BLK_BYTES] ##1 (!pop && ready))
		else $error("extract_fifo: pop run broken or block not held");

	// Load only starts from a full FIFO
	assert property (@(posedge clk) disable iff (!n_rst) $rose(pop) |-> full)
		else $error("extract_fifo: load started without full FIFO");

endmodule

// ==== design/wb_block_regs.sv ====
// Wishbone register block
`timescale 1ns/1ps
`include "blk_params.svh"

module wb_block_regs import bus_pkg::*, block_pkg::*; (
	input  logic                 clk,
	input  logic                 n_rst,
	input  logic                 cyc,
	input  logic                 stb,
	input  logic                 we,
	input  logic [`WB_AW-1:0]    adr,
	input  logic [`WB_DW-1:0]    dat_i,
	input  logic [`WB_DW/8-1:0]  sel,
	output logic [`WB_DW-1:0]    dat_o,
	output logic                 ack,
	input  logic                 fifo_full,
	output logic                 push,
	output logic [7:0]           wdata,
	input  logic                 ready,
	input  block_t               block,
	output logic                 blk_release
);

	reg_addr_t reg_sel;
	logic req;
	logic data_wr;
	logic stall;
	logic [`WB_DW-1:0] rd_word;

	// Word decode ignores the byte offset bits
	assign reg_sel = reg_addr_t'({adr[`WB_AW-1:2], 2'b00});

	// New request is masked during the ack cycle
	assign req = cyc && stb && !ack;

	assign data_wr = req && we && (reg_sel == DATA);

	// Back-pressure while the FIFO has no free slot
	assign stall = data_wr && fifo_full;

	assign push = data_wr && !fifo_full && sel[0];
	assign wdata = dat_i[7:0];

	assign blk_release = req && we && (reg_sel == STATUS) && sel[0] && dat_i[STAT_VALID];

	always_comb begin
		rd_word = '0;
		case (reg_sel)
			STATUS: begin
				rd_word[STAT_VALID] = ready;
				rd_word[STAT_FULL] = fifo_full;
			end
			BLK0: rd_word = block.words[0];
			BLK1: rd_word = block.words[1];
			BLK2: rd_word = block.words[2];
			BLK3: rd_word = block.words[3];
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			ack <= 1'b0;
		else
			ack <= req && !stall;
	end

	// Read data captured together with the ack
	always_ff @(posedge clk) begin
		if (req && !we)
			dat_o <= rd_word;
	end

	// Ack only answers a cycle the master still holds
	assert property (@(posedge clk) disable iff (!n_rst) ack |-> (cyc && stb))
		else $error("wb_block_regs: ack outside an active cycle");

endmodule

// ==== verif/tb_block_collector.sv ====
// Block collector testbench
`timescale 1ns/1ps
`include "blk_params.svh"

module tb_block_collector;

	// Register addresses as seen from the bus
	localparam logic [`WB_AW-1:0] ADR_DATA   = 5'h00;
	localparam logic [`WB_AW-1:0] ADR_STATUS = 5'h04;
	localparam logic [`WB_AW-1:0] ADR_BLK0   = 5'h10;

	// Cycle limits for the bus and for status polling
	localparam int ACK_LIMIT   = 64;
	localparam int STALL_LIMIT = 24;
	localparam int POLL_LIMIT  = 50;
	localparam int DRAIN_LIMIT = 8;

	logic                 clk;
	logic                 n_rst;
	logic                 cyc;
	logic                 stb;
	logic                 we;
	logic [`WB_AW-1:0]    adr;
	logic [`WB_DW-1:0]    dat_i;
	logic [`WB_DW/8-1:0]  sel;
	logic [`WB_DW-1:0]    dat_o;
	logic                 ack;

	integer seed;
	int check_count;
	int error_count;
	int timeout_count;

	// Comparisons waiting for the checker
	string             cmp_name[$];
	logic [`WB_DW-1:0] cmp_exp[$];
	logic [`WB_DW-1:0] cmp_act[$];

	// Checker working copies
	string             chk_name;
	logic [`WB_DW-1:0] chk_exp;
	logic [`WB_DW-1:0] chk_act;

	// Random byte sets, one per block
	logic [7:0] set1[$];
	logic [7:0] set2[$];
	logic [7:0] set3[$];
	logic [7:0] held_byte;

	block_collector_top dut0 (
		.clk(clk),
		.n_rst(n_rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_i(dat_i),
		.sel(sel),
		.dat_o(dat_o),
		.ack(ack)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// Expected block, first written byte in bits 7 to 0
	function automatic logic [`BLK_WIDTH-1:0] ref_block(input logic [7:0] bytes_q[$]);
		logic [`BLK_WIDTH-1:0] blk;
		int i;
		blk = '0;
		for (i = 0; i < bytes_q.size() && i < `BLK_BYTES; i++)
			blk[8*i +: 8] = bytes_q[i];
		return blk;
	endfunction

	function automatic logic [7:0] random_byte();
		return 8'($random(seed));
	endfunction

	// Hand one comparison to the checker
	task automatic expect_word(input string name, input logic [`WB_DW-1:0] exp,
			input logic [`WB_DW-1:0] act);
		cmp_name.push_back(name);
		cmp_exp.push_back(exp);
		cmp_act.push_back(act);
	endtask

	// Checker runs on the falling edge, away from the bus activity
	always @(negedge clk) begin
		while (cmp_act.size() != 0) begin
			chk_name = cmp_name.pop_front();
			chk_exp = cmp_exp.pop_front();
			chk_act = cmp_act.pop_front();
			check_count++;
			assert (chk_act === chk_exp)
			else begin
				error_count++;
				$display("Fail %s: expected %h, actual %h", chk_name, chk_exp, chk_act);
			end
		end
	end

	// One classic cycle, abandoned if no ack comes within limit cycles
	task automatic bus_cycle(input logic is_write, input logic [`WB_AW-1:0] addr,
			input logic [`WB_DW-1:0] wdat, input int limit,
			output logic [`WB_DW-1:0] rdat, output bit acked);
		int waited;
		acked = 1'b0;
		rdat = '0;
		waited = 0;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= is_write;
		adr <= addr;
		dat_i <= wdat;
		sel <= 4'hF;
		while (!acked && waited < limit) begin
			@(posedge clk);
			waited++;
			if (ack) begin
				acked = 1'b1;
				rdat = dat_o;
			end
		end
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic bus_write(input string name, input logic [`WB_AW-1:0] addr,
			input logic [`WB_DW-1:0] data);
		logic [`WB_DW-1:0] unused;
		bit acked;
		bus_cycle(1'b1, addr, data, ACK_LIMIT, unused, acked);
		assert (acked)
		else begin
			timeout_count++;
			$display("Timeout in %s: no ack for write to address %h after %0d cycles",
				name, addr, ACK_LIMIT);
		end
	endtask

	task automatic bus_read(input string name, input logic [`WB_AW-1:0] addr,
			output logic [`WB_DW-1:0] data);
		bit acked;
		bus_cycle(1'b0, addr, '0, ACK_LIMIT, data, acked);
		assert (acked)
		else begin
			timeout_count++;
			$display("Timeout in %s: no ack for read of address %h after %0d cycles",
				name, addr, ACK_LIMIT);
		end
	endtask

	// Write count bytes of a set to DATA, starting at index first
	task automatic write_bytes(input string name, input logic [7:0] q[$],
			input int first, input int count);
		int i;
		for (i = first; i < first + count; i++)
			bus_write(name, ADR_DATA, {24'h0, q[i]});
	endtask

	// Status bit 0 written high frees the held block
	task automatic release_block(input string name);
		bus_write(name, ADR_STATUS, 32'h1);
	endtask

	task automatic wait_valid(input string name);
		logic [`WB_DW-1:0] st;
		int polls;
		st = '0;
		polls = 0;
		while (!st[0] && polls < POLL_LIMIT) begin
			bus_read(name, ADR_STATUS, st);
			polls++;
		end
		assert (st[0])
		else begin
			timeout_count++;
			$display("Timeout in %s: valid bit still low after %0d status reads",
				name, POLL_LIMIT);
		end
	endtask

	task automatic check_status(input string name, input logic [`WB_DW-1:0] exp);
		logic [`WB_DW-1:0] st;
		bus_read(name, ADR_STATUS, st);
		expect_word(name, exp, st);
	endtask

	// All four block words against the expected block
	task automatic check_block(input string name, input logic [`BLK_WIDTH-1:0] exp);
		logic [`WB_DW-1:0] word;
		int w;
		for (w = 0; w < `BLK_WIDTH / `WB_DW; w++) begin
			bus_read(name, ADR_BLK0 + 5'(4 * w), word);
			expect_word($sformatf("%s word %0d", name, w), exp[`WB_DW*w +: `WB_DW], word);
		end
	endtask

	initial begin
		logic [`WB_DW-1:0] word;
		bit acked;
		int i;
		seed = 88998;
		check_count = 0;
		error_count = 0;
		timeout_count = 0;
		n_rst = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_i = '0;
		sel = '0;

		for (i = 0; i < `BLK_BYTES; i++)
			set1.push_back(random_byte());
		for (i = 0; i < `BLK_BYTES; i++)
			set2.push_back(random_byte());
		for (i = 0; i < `BLK_BYTES; i++)
			set3.push_back(random_byte());

		repeat (2) @(posedge clk);
		n_rst <= 1'b1;

		// Nothing held and nothing buffered
		check_status("reset_status", 32'h0);
		check_block("reset_block", '0);

		// One byte short of a block
		write_bytes("partial", set1, 0, 15);
		check_status("partial_status", 32'h0);

		// Last byte completes the first block
		write_bytes("first_block", set1, 15, 1);
		wait_valid("first_block");
		check_status("first_block_status", 32'h1);
		check_block("first_block", ref_block(set1));

		// Second block buffered behind the held one
		write_bytes("overlap", set2, 0, `BLK_BYTES);
		check_status("overlap_status", 32'h3);
		check_block("overlap_held", ref_block(set1));

		// FIFO full and block held, so this write must stall
		held_byte = set3[0];
		bus_cycle(1'b1, ADR_DATA, {24'h0, held_byte}, STALL_LIMIT, word, acked);
		check_count++;
		assert (!acked)
		else begin
			error_count++;
			$display("Error in stall: write to a full FIFO was acked");
		end
		check_status("stall_status", 32'h3);

		// Release lets the second block load, the retried write then lands
		release_block("overlap_release");
		bus_write("stall_retry", ADR_DATA, {24'h0, held_byte});
		wait_valid("overlap_second");
		check_block("overlap_second", ref_block(set2));
		check_status("third_partial_status", 32'h1);

		// Stalled byte opens the third block
		write_bytes("third_block", set3, 1, 15);
		check_status("third_full_status", 32'h3);
		release_block("second_release");
		wait_valid("third_block");
		check_block("third_block", ref_block(set3));
		bus_read("third_byte0", ADR_BLK0, word);
		expect_word("third_byte0", {24'h0, held_byte}, {24'h0, word[7:0]});

		release_block("third_release");
		check_status("final_status", 32'h0);

		// Give the checker time to empty its queue
		i = 0;
		while (cmp_act.size() != 0 && i < DRAIN_LIMIT) begin
			@(posedge clk);
			i++;
		end
		if (cmp_act.size() != 0) begin
			timeout_count++;
			$display("Timeout at end of run: %0d comparisons never checked", cmp_act.size());
		end

		$display("Checks: %0d, errors: %0d, timeouts: %0d",
			check_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
